/* src/network_params.svh */
// network sizing macros shared by the packages and the RTL
// input and output neuron counts, weight and potential widths,
// and the firing threshold of the integrate-and-fire layer

`ifndef NETWORK_PARAMS_SVH
`define NETWORK_PARAMS_SVH

// one layer, fully connected
`define NET_NUM_IN 4
`define NET_NUM_OUT 4

// weights are signed, potentials unsigned and clamped
`define WEIGHT_WIDTH 8
`define POT_WIDTH 12

// an output fires when its potential reaches this value
`define NET_THRESHOLD 100

`endif

/* src/network_config.sv */
// network types: weights, potentials, spike vectors,
// host command word and weight bank request

`include "network_params.svh"

package network_config;
    // total weights in the matrix, also the bank depth
    localparam int NUM_WEIGHTS = `NET_NUM_IN * `NET_NUM_OUT;

    // host command kinds
    localparam logic CMD_WEIGHT = 1'b0;
    localparam logic CMD_SPIKES = 1'b1;

    typedef logic signed [`WEIGHT_WIDTH-1:0] weight_t;
    typedef logic [`POT_WIDTH-1:0] potential_t;
    typedef logic [`NET_NUM_IN-1:0] spikes_in_t;
    typedef logic [`NET_NUM_OUT-1:0] spikes_out_t;
    // weight from input i to output j sits at i * NET_NUM_OUT + j
    typedef logic [$clog2(NUM_WEIGHTS)-1:0] weight_addr_t;

    // data carries a weight, or the spike vector in its low bits
    typedef struct packed {
        logic kind;
        weight_addr_t addr;
        weight_t data;
    } host_cmd_t;

    typedef struct packed {
        logic we;
        weight_addr_t addr;
        weight_t wdata;
    } mem_req_t;
endpackage

/* src/sink_config.sv */
// sink output word type and the longest run of words per vector

`include "network_params.svh"

package sink_config;
    // values 0 through NET_NUM_OUT must fit
    localparam int SNK_WIDTH = $clog2(`NET_NUM_OUT + 1);
    // every fired index plus the count
    localparam int MAX_OUT_PER_RUN = `NET_NUM_OUT + 1;

    typedef logic [SNK_WIDTH-1:0] snk_t;
endpackage

/* src/weight_bank.sv */
// single-port weight memory shared by source and core
// fixed priority with the source first and same-cycle grant pulses
// read data is registered and valid the cycle after the grant

`timescale 1ns/10ps

module weight_bank (
    input logic clk,
    input logic arstn,
    // request levels from both ports
    input logic src_req,
    input logic core_req,
    input network_config::mem_req_t src_cmd,
    input network_config::mem_req_t core_cmd,
    // one-cycle grants
    output logic src_grant,
    output logic core_grant,
    output network_config::weight_t rdata
);
    network_config::weight_t mem [network_config::NUM_WEIGHTS];
    network_config::mem_req_t sel;

    // source always wins and the core only gets an idle port
    assign src_grant = src_req;
    assign core_grant = core_req && !src_req;

    // the granted request drives the single port
    assign sel = src_req ? src_cmd : core_cmd;

    always_ff @(posedge clk) begin: mem_write
        if ((src_grant || core_grant) && sel.we) begin
            mem[sel.addr] <= sel.wdata;
        end
    end

    // registered read data is held until the next granted read
    always_ff @(posedge clk or negedge arstn) begin: mem_read
        if (!arstn) begin
            rdata <= '0;
        end else if ((src_grant || core_grant) && !sel.we) begin
            rdata <= mem[sel.addr];
        end
    end

endmodule

/* src/network_source.sv */
// host command decoder for the network
// weight writes go to the bank and spike vectors go to the core
// one command is held at a time and cmd_ready is high only in idle

`timescale 1ns/10ps
`include "network_params.svh"

module network_source (
    input logic clk,
    input logic arstn,
    // host port
    input network_config::host_cmd_t cmd,
    input logic cmd_valid,
    output logic cmd_ready,
    // weight bank port
    output logic src_req,
    output network_config::mem_req_t src_cmd,
    input logic src_grant,
    // spike hand-off to the core
    output network_config::spikes_in_t in_spikes,
    output logic in_valid,
    input logic in_ready
);
    typedef enum logic [1:0] {S_IDLE, S_WRITE, S_HANDOFF} state_t;

    state_t state;
    network_config::host_cmd_t held;

    assign cmd_ready = (state == S_IDLE);

    // bank write request is held until granted
    assign src_req = (state == S_WRITE);
    assign src_cmd = '{we: 1'b1, addr: held.addr, wdata: held.data};

    // spike vector lives in the low bits of the data field
    assign in_valid = (state == S_HANDOFF);
    assign in_spikes = held.data[`NET_NUM_IN-1:0];

    always_ff @(posedge clk or negedge arstn) begin: fsm
        if (!arstn) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_valid) begin
                        state <= (cmd.kind == network_config::CMD_SPIKES) ? S_HANDOFF : S_WRITE;
                    end
                end
                // write lands on the grant edge
                S_WRITE: if (src_grant) state <= S_IDLE;
                S_HANDOFF: if (in_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // command payload is captured on accept
    always_ff @(posedge clk) begin: latch_cmd
        if (cmd_valid && cmd_ready) begin
            held <= cmd;
        end
    end

endmodule

/* src/network_core.sv */
// sequential integrate-and-fire layer
// walks every (input, output) weight through the shared bank,
// accumulates clamped potentials, then fires and resets
// potentials persist across runs

`timescale 1ns/10ps
`include "network_params.svh"

module network_core (
    input logic clk,
    input logic arstn,
    // spike vector from the source
    input network_config::spikes_in_t in_spikes,
    input logic in_valid,
    output logic in_ready,
    // weight bank port
    output logic core_req,
    output network_config::mem_req_t core_cmd,
    input logic core_grant,
    input network_config::weight_t rdata,
    // output spike vector to the sink
    output network_config::spikes_out_t net_out,
    output logic net_valid,
    input logic net_ready
);
    localparam int IW = $clog2(`NET_NUM_IN);
    localparam int OW = $clog2(`NET_NUM_OUT);
    localparam int SW = `POT_WIDTH + 2;

    typedef enum logic [2:0] {C_IDLE, C_REQ, C_WAIT, C_FIRE, C_OUT} state_t;

    state_t state;
    network_config::spikes_in_t spikes;
    network_config::potential_t pot [`NET_NUM_OUT];
    network_config::spikes_out_t fires;
    logic [IW-1:0] in_idx;
    logic [OW-1:0] out_idx;
    logic last_pair;
    logic signed [SW-1:0] sum;
    network_config::potential_t sum_clamped;

    assign in_ready = (state == C_IDLE);
    assign net_valid = (state == C_OUT);
    // request is dropped in C_WAIT, leaving a slot for the source
    assign core_req = (state == C_REQ);
    assign core_cmd.we = 1'b0;
    assign core_cmd.addr = network_config::weight_addr_t'(in_idx * `NET_NUM_OUT + out_idx);
    assign core_cmd.wdata = '0;

    assign last_pair = (in_idx == IW'(`NET_NUM_IN - 1)) && (out_idx == OW'(`NET_NUM_OUT - 1));

    // signed sum wide enough for max potential plus max weight
    assign sum = $signed({2'b00, pot[out_idx]}) + rdata;
    always_comb begin
        if (sum < 0) begin
            sum_clamped = '0;
        end else if (sum > $signed({2'b00, {`POT_WIDTH{1'b1}}})) begin
            sum_clamped = '1;
        end else begin
            sum_clamped = sum[`POT_WIDTH-1:0];
        end
    end

    always_comb begin
        foreach (fires[j]) fires[j] = (pot[j] >= network_config::potential_t'(`NET_THRESHOLD));
    end

    always_ff @(posedge clk or negedge arstn) begin: fsm
        if (!arstn) begin
            state <= C_IDLE;
            in_idx <= '0;
            out_idx <= '0;
            foreach (pot[j]) pot[j] <= '0;
        end else begin
            case (state)
                C_IDLE: if (in_valid) begin
                    in_idx <= '0;
                    out_idx <= '0;
                    state <= C_REQ;
                end
                C_REQ: if (core_grant) state <= C_WAIT;
                C_WAIT: begin
                    // rdata holds the weight for (in_idx, out_idx)
                    if (spikes[in_idx]) pot[out_idx] <= sum_clamped;
                    if (last_pair) begin
                        state <= C_FIRE;
                    end else begin
                        if (out_idx == OW'(`NET_NUM_OUT - 1)) in_idx <= in_idx + 1'b1;
                        out_idx <= (out_idx == OW'(`NET_NUM_OUT - 1)) ? '0 : out_idx + 1'b1;
                        state <= C_REQ;
                    end
                end
                C_FIRE: begin
                    // fired outputs return to rest while the others keep their charge
                    foreach (pot[j]) if (fires[j]) pot[j] <= '0;
                    state <= C_OUT;
                end
                C_OUT: if (net_ready) state <= C_IDLE;
                default: state <= C_IDLE;
            endcase
        end
    end

    // payload captures
    always_ff @(posedge clk) begin: payload
        if (in_valid && in_ready) spikes <= in_spikes;
        if (state == C_FIRE) net_out <= fires;
    end

endmodule

/* src/network_sink.sv */
// output vector serializer
// scans a latched spike vector over NET_NUM_OUT + 1 cycles,
// pushing fired indices in ascending order and the count last,
// then pops the stack so the count comes first and the indices descend

`timescale 1ns/10ps
`include "network_params.svh"

module network_sink (
    input logic clk,
    input logic arstn,
    // core handshake
    input logic net_valid,
    output logic net_ready,
    input network_config::spikes_out_t net_out,
    // output stream handshake
    input logic snk_ready,
    output logic snk_valid,
    output sink_config::snk_t snk
);
    // stack depth runs 0 through MAX_OUT_PER_RUN
    localparam int DW = $clog2(sink_config::MAX_OUT_PER_RUN + 1);

    network_config::spikes_out_t fires;
    sink_config::snk_t stack [sink_config::MAX_OUT_PER_RUN];
    sink_config::snk_t scan_idx;
    logic scanning;
    logic [DW-1:0] depth;
    logic [DW-1:0] top_idx;
    logic accept;
    logic pop;
    logic push;
    logic scan_last;

    assign accept = net_valid && net_ready;
    assign pop = snk_valid && snk_ready;

    // busy from accept until the stack is empty again
    assign net_ready = !scanning && (depth == '0);
    assign snk_valid = !scanning && (depth != '0);

    // final scan cycle always pushes the count
    assign scan_last = (scan_idx == sink_config::snk_t'(`NET_NUM_OUT));
    assign push = scanning && (scan_last || fires[scan_idx[$clog2(`NET_NUM_OUT)-1:0]]);

    assign top_idx = depth - 1'b1;
    assign snk = stack[top_idx];

    always_ff @(posedge clk or negedge arstn) begin: scan_ctrl
        if (!arstn) begin
            scanning <= 1'b0;
            scan_idx <= '0;
        end else if (accept) begin
            scanning <= 1'b1;
            scan_idx <= '0;
        end else if (scanning) begin
            // one vector bit per cycle and then the count
            scan_idx <= scan_idx + 1'b1;
            if (scan_last) scanning <= 1'b0;
        end
    end

    // depth counts pushes during the scan and pops afterwards
    always_ff @(posedge clk or negedge arstn) begin: stack_depth
        if (!arstn) begin
            depth <= '0;
        end else if (push) begin
            depth <= depth + 1'b1;
        end else if (pop) begin
            depth <= depth - 1'b1;
        end
    end

    // stack contents are written at the current depth
    always_ff @(posedge clk) begin: stack_write
        if (push) begin
            // before the push depth equals the number of fired indices
            stack[depth] <= scan_last ? sink_config::snk_t'(depth) : scan_idx;
        end
    end

    always_ff @(posedge clk) begin: latch_vector
        if (accept) begin
            fires <= net_out;
        end
    end

endmodule

/* src/network_top.sv */
// spiking network accelerator top level
// host commands feed the source, which shares the weight bank
// with the core; the sink serializes each output vector

`timescale 1ns/10ps

module network_top (
    input logic clk,
    input logic arstn,
    // host command port
    input network_config::host_cmd_t cmd,
    input logic cmd_valid,
    output logic cmd_ready,
    // serialized output stream
    output sink_config::snk_t snk,
    output logic snk_valid,
    input logic snk_ready
);
    // source to bank
    logic src_req;
    logic src_grant;
    network_config::mem_req_t src_cmd;
    // core to bank
    logic core_req;
    logic core_grant;
    network_config::mem_req_t core_cmd;
    network_config::weight_t rdata;
    // source to core
    network_config::spikes_in_t in_spikes;
    logic in_valid;
    logic in_ready;
    // core to sink
    network_config::spikes_out_t net_out;
    logic net_valid;
    logic net_ready;

    network_source source0 (.clk, .arstn, .cmd, .cmd_valid, .cmd_ready, .src_req, .src_cmd,
        .src_grant, .in_spikes, .in_valid, .in_ready);

    weight_bank bank0 (.clk, .arstn, .src_req, .core_req, .src_cmd, .core_cmd, .src_grant,
        .core_grant, .rdata);

    network_core core0 (.clk, .arstn, .in_spikes, .in_valid, .in_ready, .core_req, .core_cmd,
        .core_grant, .rdata, .net_out, .net_valid, .net_ready);

    network_sink sink0 (.clk, .arstn, .net_valid, .net_ready, .net_out, .snk_ready,
        .snk_valid, .snk);

endmodule

/* tb/tb_clock.sv */
// clock and reset source for the testbench
// 20 ns clock, reset held low for 5 cycles

`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic arstn
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // release just after an edge, away from the sampling point
    initial begin
        arstn = 1'b0;
        repeat (5) @(posedge clk);
        #2 arstn = 1'b1;
    end
endmodule

/* tb/network_tb.sv */
// testbench for network_top
// reference model of the integrate-and-fire layer and sink ordering,
// stimulus for the directed and random tests, output compare process,
// watchdog and final report

`timescale 1ns/10ps
`include "network_params.svh"

module network_tb;
    localparam int NW = network_config::NUM_WEIGHTS;
    localparam int POT_MAX = (1 << `POT_WIDTH) - 1;
    localparam int RANDOM_RUNS = 30;
    // 16 weights loaded in each of five tests plus two extra writes per random run
    localparam int TOTAL_WRITES = 5 * NW + 2 * RANDOM_RUNS;
    localparam int TOTAL_RUNS = 1 + `NET_NUM_IN + 3 + 6 + RANDOM_RUNS;
    localparam int TIMEOUT_CYCLES = 40 * (TOTAL_WRITES + TOTAL_RUNS);
    localparam int DRAIN_CYCLES = 40 * NW;

    logic clk;
    logic arstn;
    network_config::host_cmd_t cmd;
    logic cmd_valid;
    logic cmd_ready;
    sink_config::snk_t snk;
    logic snk_valid;
    logic snk_ready;

    // model state and expected stream
    int model_w [NW];
    int model_pot [`NET_NUM_OUT];
    int exp_q [$];
    int errors;
    int tests_passed;
    int tests_failed;
    logic random_ready;

    tb_clock clock0 (.clk, .arstn);

    network_top dut0 (.clk, .arstn, .cmd, .cmd_valid, .cmd_ready, .snk, .snk_valid, .snk_ready);

    // one run of the layer with pairs walked input-major like the hardware
    // count goes out first and then fired indices from high to low
    function automatic void expect_run(input network_config::spikes_in_t sp);
        int fired [$];
        int p;
        for (int i = 0; i < `NET_NUM_IN; i++) begin
            for (int j = 0; j < `NET_NUM_OUT; j++) begin
                if (sp[i]) begin
                    p = model_pot[j] + model_w[i * `NET_NUM_OUT + j];
                    // clamp at every step and not just at the end
                    model_pot[j] = (p < 0) ? 0 : ((p > POT_MAX) ? POT_MAX : p);
                end
            end
        end
        for (int j = 0; j < `NET_NUM_OUT; j++) begin
            if (model_pot[j] >= `NET_THRESHOLD) begin
                fired.push_back(j);
                model_pot[j] = 0;
            end
        end
        exp_q.push_back(fired.size());
        for (int k = fired.size() - 1; k >= 0; k--) exp_q.push_back(fired[k]);
    endfunction

    // called 2 ns after an edge and returns at the same phase
    task automatic send_cmd(input logic kind, input int addr, input network_config::weight_t data);
        cmd.kind = kind;
        cmd.addr = network_config::weight_addr_t'(addr);
        cmd.data = data;
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            @(posedge clk);
            #2;
        end
        // transfer happens on this edge
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic write_weight(input int addr, input int w);
        model_w[addr] = w;
        send_cmd(network_config::CMD_WEIGHT, addr, network_config::weight_t'(w));
    endtask

    task automatic wait_drain(input network_config::spikes_in_t sp);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
            @(posedge clk);
            #2;
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("spike vector %h: %0d output words never arrived", sp, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    // expected words are queued before the DUT can produce them
    task automatic run_vector(input network_config::spikes_in_t sp);
        network_config::weight_t data;
        expect_run(sp);
        data = '0;
        data[`NET_NUM_IN-1:0] = sp;
        send_cmd(network_config::CMD_SPIKES, 0, data);
        wait_drain(sp);
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", name, errors - start_errors);
        end
    endtask

    // ready toggles 2 ns after the edge and is sampled 1 ns later
    initial begin: compare
        int exp_word;
        snk_ready = 1'b0;
        @(posedge arstn);
        forever begin
            @(posedge clk);
            #2;
            snk_ready = random_ready ? 1'($urandom_range(0, 1)) : 1'b1;
            #1;
            if (snk_valid && snk_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("unexpected extra word %h on the output stream", snk);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_word = exp_q.pop_front();
                    assert (snk == sink_config::snk_t'(exp_word)) else begin
                        $display("FAILED snk expected %h actual %h",
                            sink_config::snk_t'(exp_word), snk);
                        errors++;
                    end
                end
            end
        end
    end

    // watchdog sized from the number of writes and runs
    initial begin: watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d words still expected", cycles, exp_q.size());
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin: stimulus
        int start;
        void'($urandom(32'hd3c375e0));
        cmd = '0;
        cmd_valid = 1'b0;
        random_ready = 1'b0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        foreach (model_w[a]) model_w[a] = 0;
        foreach (model_pot[j]) model_pot[j] = 0;
        wait (arstn);
        @(posedge clk);
        #2;

        // nothing can fire with all weights at zero
        start = errors;
        for (int a = 0; a < NW; a++) write_weight(a, 0);
        run_vector('1);
        report_test("zero weights give count 0", start);

        // strong diagonal so each input fires only its own output
        start = errors;
        for (int i = 0; i < `NET_NUM_IN; i++) begin
            for (int j = 0; j < `NET_NUM_OUT; j++) begin
                write_weight(i * `NET_NUM_OUT + j, (i == j) ? 110 : 0);
            end
        end
        for (int k = 0; k < `NET_NUM_IN; k++) run_vector(network_config::spikes_in_t'(1 << k));
        report_test("diagonal single fires", start);

        // several outputs at once with the last run firing all four
        start = errors;
        for (int i = 0; i < `NET_NUM_IN; i++) begin
            for (int j = 0; j < `NET_NUM_OUT; j++) begin
                write_weight(i * `NET_NUM_OUT + j,
                    (i == 0) ? 60 : ((i == 1 && j % 2 == 1) ? 50 : ((i == 2) ? 100 : 0)));
            end
        end
        run_vector(4'b0011);
        run_vector(4'b0001);
        run_vector(4'b0111);
        report_test("multiple fires in descending order", start);

        // charge builds over runs and a big negative weight clamps at zero
        start = errors;
        for (int i = 0; i < `NET_NUM_IN; i++) begin
            for (int j = 0; j < `NET_NUM_OUT; j++) begin
                write_weight(i * `NET_NUM_OUT + j,
                    (i == 0) ? 30 + 10 * j : ((i == 1) ? -100 : ((i == 2) ? 20 : 0)));
            end
        end
        run_vector(4'b0001);
        run_vector(4'b0001);
        run_vector(4'b0001);
        run_vector(4'b0010);
        run_vector(4'b0101);
        run_vector(4'b0001);
        report_test("accumulate, fire, reset and clamp", start);

        // random weights and vectors under output back-pressure
        start = errors;
        random_ready = 1'b1;
        for (int a = 0; a < NW; a++) write_weight(a, int'($urandom_range(0, 100)) - 40);
        for (int r = 0; r < RANDOM_RUNS; r++) begin
            write_weight(int'($urandom_range(0, NW - 1)), int'($urandom_range(0, 100)) - 40);
            write_weight(int'($urandom_range(0, NW - 1)), int'($urandom_range(0, 100)) - 40);
            run_vector(network_config::spikes_in_t'($urandom_range(0, (1 << `NET_NUM_IN) - 1)));
        end
        // nothing may follow the last expected word
        repeat (2 * sink_config::MAX_OUT_PER_RUN) @(posedge clk);
        #2;
        assert (!snk_valid) else begin
            $display("output stream still has words after the last run");
            errors++;
        end
        report_test("random runs with back-pressure", start);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

/* vlog.f */
+incdir+src
src/network_config.sv
src/sink_config.sv
src/weight_bank.sv
src/network_source.sv
src/network_core.sv
src/network_sink.sv
src/network_top.sv
tb/tb_clock.sv
tb/network_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = network_tb
FILELIST  = vlog.f

SOURCES = $(wildcard src/*.sv src/*.svh tb/*.sv)
BIN     = obj_dir/V$(TOP)
LOG     = sim.log

.PHONY: all run clean

all: $(BIN)

obj_dir/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
